// File: usb_rx_pkg.sv
// line codes are {D+, D-} after the synchronizer
// fifo_depth must equal 2**fifo_ptr_w, samples_per_bit must be a power of two
package usb_rx_pkg;

  localparam logic [1:0] line_j = 2'b10;  // idle, D+ high
  localparam logic [1:0] line_k = 2'b01;
  localparam logic [1:0] line_z = 2'b00;  // single-ended zero

  localparam int samples_per_bit = 4;  // 48 MHz clock, 12 Mbit/s line
  localparam int stuff_limit     = 6;  // ones before a stuffed zero

  // one FIFO word, either a received byte or an end-of-packet marker
  typedef struct packed {
    logic       eop_mark;  // byte is zero when set
    logic [7:0] data;
  } rx_entry_t;

  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = 4;

  // Wishbone word addresses
  localparam int adr_w = 2;
  localparam logic [adr_w-1:0] reg_status = 2'd0;
  localparam logic [adr_w-1:0] reg_data   = 2'd1;
  localparam logic [adr_w-1:0] reg_ctrl   = 2'd2;
  localparam logic [adr_w-1:0] reg_errcnt = 2'd3;

endpackage

// File: usb_rx.sv
// Full-speed receiver with fixed 4x sampling and no clock recovery.
// The stuffing count includes the last SYNC bit; a stuffed bit is skipped unchecked.
// An SE0 inside a byte sends the FSM to error; it resumes after SE0 and then idle J.
`timescale 1ns/1ps

module usb_rx (
  input  logic       clk,
  input  logic       reset,
  input  logic       usb_p,
  input  logic       usb_n,
  output logic       byte_valid,
  output logic       eop,
  output logic       line_err,
  output logic [7:0] data
);

  typedef enum logic [2:0] {
    st_reset,
    st_idle,
    st_sync,
    st_data,
    st_end,
    st_error
  } state_t;

  logic [2:0] sync_p;  // D+ synchronizer chain
  logic [2:0] sync_n;  // D- synchronizer chain
  logic [1:0] line;    // synchronized {D+, D-}
  logic       stable;  // last two samples agree
  logic       rx_bit;  // NRZI decoded bit
  logic       sample;  // bit sample point

  state_t     state;
  logic [1:0] phase;   // line state at previous bit
  logic [$clog2(usb_rx_pkg::samples_per_bit)-1:0] tick;
  logic [2:0] bits;    // bit index, or SE0 count in st_end
  logic [2:0] ones;    // consecutive ones for destuffing

  always_ff @(posedge clk)
  begin
    sync_p <= {sync_p[1:0], usb_p};
    sync_n <= {sync_n[1:0], usb_n};
  end

  assign line   = {sync_p[2], sync_n[2]};
  assign stable = (sync_p[2] == sync_p[1]) && (sync_n[2] == sync_n[1]);
  assign rx_bit = (line == phase);  // no transition reads as one
  assign sample = (tick == '0);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= st_reset;
      phase      <= usb_rx_pkg::line_j;
      tick       <= '0;
      bits       <= '0;
      ones       <= '0;
      byte_valid <= 1'b0;
      eop        <= 1'b0;
      line_err   <= 1'b0;
    end
    else
    begin
      byte_valid <= 1'b0;
      eop        <= 1'b0;
      line_err   <= 1'b0;
      if (int'(tick) == usb_rx_pkg::samples_per_bit - 1)
        tick <= '0;
      else
        tick <= tick + 1'b1;

      case (state)
        st_reset:
          if (stable && line == usb_rx_pkg::line_j)
            state <= st_idle;  // bus back to idle
        st_idle:
          if (stable && line == usb_rx_pkg::line_k)
          begin
            state <= st_sync;  // first K of SYNC
            phase <= usb_rx_pkg::line_j;
            tick  <= '0;       // next cycle is mid-bit
            bits  <= '0;
            ones  <= '0;
          end
          else if (stable && line == usb_rx_pkg::line_z)
            state <= st_reset;
        st_sync:
          if (sample)
          begin
            // SYNC decodes as seven zeros and a one
            if (!stable || line == usb_rx_pkg::line_z || rx_bit != (bits == 3'd7))
            begin
              state    <= st_error;
              line_err <= 1'b1;
            end
            else
            begin
              phase <= line;
              bits  <= bits + 1'b1;
              if (bits == 3'd7)
              begin
                state <= st_data;
                ones  <= 3'd1;  // last SYNC bit counts for stuffing
              end
            end
          end
        st_data:
          if (sample)
          begin
            if (stable && line == usb_rx_pkg::line_z && bits == 3'd0)
            begin
              state <= st_end;  // first SE0 on a byte boundary
              bits  <= 3'd1;
            end
            else if (!stable || line == usb_rx_pkg::line_z)
            begin
              state    <= st_error;  // SE0 inside a byte or glitch
              line_err <= 1'b1;
            end
            else
            begin
              phase <= line;
              if (int'(ones) == usb_rx_pkg::stuff_limit)
                ones <= '0;  // drop stuffed zero
              else
              begin
                data <= {rx_bit, data[7:1]};  // LSB first
                ones <= rx_bit ? ones + 1'b1 : 3'd0;
                bits <= bits + 1'b1;
                if (bits == 3'd7)
                  byte_valid <= 1'b1;
              end
            end
          end
        st_end:
          if (sample)
          begin
            if (bits == 3'd1 && stable && line == usb_rx_pkg::line_z)
              bits <= 3'd2;  // second SE0
            else if (bits == 3'd2 && stable && line == usb_rx_pkg::line_j)
            begin
              state <= st_idle;
              eop   <= 1'b1;
            end
            else
            begin
              state    <= st_error;
              line_err <= 1'b1;
            end
          end
        st_error:
          if (stable && line == usb_rx_pkg::line_z)
            state <= st_reset;  // wait for SE0 before resync
        default:
        begin
          state    <= st_error;
          line_err <= 1'b1;
        end
      endcase
    end
  end

endmodule

// File: usb_rx_fifo.sv
// Show-ahead FIFO, rdata is valid whenever empty is low.
// A push while full is dropped and flagged on overflow_evt, a pop while empty is ignored.
`timescale 1ns/1ps

module usb_rx_fifo #(
  parameter type payload_t = usb_rx_pkg::rx_entry_t
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  logic     pop,
  input  payload_t wdata,
  output payload_t rdata,
  output logic     full,
  output logic     empty,
  output logic     overflow_evt
);

  payload_t mem [usb_rx_pkg::fifo_depth];

  logic [usb_rx_pkg::fifo_ptr_w:0] wr_ptr;  // msb is the wrap bit
  logic [usb_rx_pkg::fifo_ptr_w:0] rd_ptr;
  logic                            do_push;
  logic                            do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[usb_rx_pkg::fifo_ptr_w] != rd_ptr[usb_rx_pkg::fifo_ptr_w])
              && (wr_ptr[usb_rx_pkg::fifo_ptr_w-1:0] == rd_ptr[usb_rx_pkg::fifo_ptr_w-1:0]);

  assign do_push      = push && !full;
  assign do_pop       = pop && !empty;
  assign overflow_evt = push && full;  // dropped entry

  assign rdata = mem[rd_ptr[usb_rx_pkg::fifo_ptr_w-1:0]];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr[usb_rx_pkg::fifo_ptr_w-1:0]] <= wdata;
  end

endmodule

// File: usb_rx_regs.sv
// Wishbone classic slave, 32-bit data, one registered ack per request.
// A data read pops in the ack cycle; an empty FIFO reads as bit 9 set.
// The error counter saturates at 255 and is not cleared by software.
`timescale 1ns/1ps

module usb_rx_regs (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [usb_rx_pkg::adr_w-1:0] adr,
  input  logic [31:0]                  dat_w,
  input  logic                         empty,
  input  logic                         full,
  input  logic                         overflow_evt,
  input  logic                         line_err,
  input  usb_rx_pkg::rx_entry_t        rdata,
  output logic [31:0]                  dat_r,
  output logic                         ack,
  output logic                         pop,
  output logic                         enable
);

  logic       req;       // request accepted this cycle
  logic       overflow;  // sticky until cleared through ctrl
  logic [7:0] err_cnt;

  // no new request in the ack cycle, so a held strobe gets one ack
  assign req = cyc && stb && !ack;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ack      <= 1'b0;
      pop      <= 1'b0;
      enable   <= 1'b0;
      overflow <= 1'b0;
      err_cnt  <= '0;
    end
    else
    begin
      ack <= req;
      // only this block pops, so non-empty now means non-empty at ack
      pop <= req && !we && adr == usb_rx_pkg::reg_data && !empty;

      if (req && we && adr == usb_rx_pkg::reg_ctrl)
      begin
        enable <= dat_w[0];
        if (dat_w[1])
          overflow <= 1'b0;  // write one to clear
      end
      if (overflow_evt)
        overflow <= 1'b1;  // new drop wins over clear

      if (line_err && err_cnt != 8'hff)
        err_cnt <= err_cnt + 1'b1;
    end
  end

  // read data captured with the request, presented with ack
  always_ff @(posedge clk)
  begin
    if (req && !we)
    begin
      case (adr)
        usb_rx_pkg::reg_status:
          dat_r <= {29'd0, overflow, full, empty};
        usb_rx_pkg::reg_data:
          if (empty)
            dat_r <= 32'h0000_0200;  // no entry available
          else
            dat_r <= {23'd0, rdata};  // eop_mark in bit 8
        usb_rx_pkg::reg_ctrl:
          dat_r <= {31'd0, enable};
        usb_rx_pkg::reg_errcnt:
          dat_r <= {24'd0, err_cnt};
        default:
          dat_r <= '0;
      endcase
    end
  end

endmodule

// File: usb_rx_top.sv
// Receive-only USB full-speed subsystem; D+ and D- are never driven.
// Nothing is queued while enable is clear; a full FIFO drops entries and sets overflow.
`timescale 1ns/1ps

module usb_rx_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         usb_p,
  input  logic                         usb_n,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [usb_rx_pkg::adr_w-1:0] adr,
  input  logic [31:0]                  dat_w,
  output logic [31:0]                  dat_r,
  output logic                         ack
);

  logic                  byte_valid;
  logic                  eop;
  logic                  line_err;
  logic [7:0]            rx_data;
  logic                  push;
  usb_rx_pkg::rx_entry_t entry;
  usb_rx_pkg::rx_entry_t rdata;
  logic                  full;
  logic                  empty;
  logic                  overflow_evt;
  logic                  pop;
  logic                  enable;

  assign push           = enable && (byte_valid || eop);
  assign entry.eop_mark = eop;
  assign entry.data     = eop ? 8'h00 : rx_data;  // marker carries no byte

  usb_rx u_rx (
    .clk        (clk),
    .reset      (reset),
    .usb_p      (usb_p),
    .usb_n      (usb_n),
    .byte_valid (byte_valid),
    .eop        (eop),
    .line_err   (line_err),
    .data       (rx_data)
  );

  usb_rx_fifo #(
    .payload_t (usb_rx_pkg::rx_entry_t)
  ) u_fifo (
    .clk          (clk),
    .reset        (reset),
    .push         (push),
    .pop          (pop),
    .wdata        (entry),
    .rdata        (rdata),
    .full         (full),
    .empty        (empty),
    .overflow_evt (overflow_evt)
  );

  usb_rx_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .empty        (empty),
    .full         (full),
    .overflow_evt (overflow_evt),
    .line_err     (line_err),
    .rdata        (rdata),
    .dat_r        (dat_r),
    .ack          (ack),
    .pop          (pop),
    .enable       (enable)
  );

endmodule

// File: usb_rx_checker.sv
// Compares every Wishbone read with the next expected value queued by the testbench.
// Assumes classic cycles with one ack per request and no pipelined requests.
`timescale 1ns/1ps

module usb_rx_checker (
  input logic        clk,
  input logic        reset,
  input logic        cyc,
  input logic        stb,
  input logic        we,
  input logic        ack,
  input logic [31:0] dat_r
);

  logic [31:0] exp_q [$];  // expected read data in order
  string       name_q [$];  // register name per expected read
  logic        req_we;      // direction of the request being acked
  logic [31:0] exp_v;
  string       exp_n;

  int checks       = 0;
  int errors       = 0;
  int test_checks  = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  task automatic expect_read(input string reg_name, input logic [31:0] value);
    exp_q.push_back(value);
    name_q.push_back(reg_name);
  endtask

  task automatic end_test(input int idx, input string what);
    if (exp_q.size() != 0)
    begin
      $display("test %0d: %0d expected reads were never acked", idx, exp_q.size());
      errors++;
      test_errors++;
      exp_q.delete();
      name_q.delete();
    end
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("test %0d %s: %s, %0d reads checked, %0d errors", idx, what,
             (test_errors == 0) ? "ok" : "failing", test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("%0d tests, %0d failing, %0d reads checked, %0d errors",
             tests_run, tests_failed, checks, errors);
  endtask

  // ack and dat_r are registered, read here as they stood during the ack cycle
  always @(posedge clk)
  begin
    if (reset)
      req_we <= 1'b0;
    else
    begin
      if (cyc && stb && !ack)
        req_we <= we;  // request sampled by the DUT this edge
      if (ack && !req_we)
      begin
        if (exp_q.size() == 0)
        begin
          $display("a read was acked with no expected value queued");
          errors++;
          test_errors++;
        end
        else
        begin
          exp_v = exp_q.pop_front();
          exp_n = name_q.pop_front();
          checks++;
          test_checks++;
          if (dat_r !== exp_v)
          begin
            $display("** Error: dat_r (%s read) expected %08h got %08h", exp_n, exp_v, dat_r);
            errors++;
            test_errors++;
          end
        end
      end
    end
  end

endmodule

// File: usb_rx_asserts.sv
// Protocol checks on the receiver and register block, bound into the top level.
`timescale 1ns/1ps

module usb_rx_asserts (
  input logic clk,
  input logic reset,
  input logic ack,
  input logic pop,
  input logic empty,
  input logic byte_valid,
  input logic eop
);

  ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack held high for two cycles");

  byte_or_eop: assert property (@(posedge clk) disable iff (reset) !(byte_valid && eop))
    else $error("byte_valid and eop high together");

  pop_not_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("pop while FIFO empty");

endmodule

bind usb_rx_top usb_rx_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .ack        (ack),
  .pop        (pop),
  .empty      (empty),
  .byte_valid (byte_valid),
  .eop        (eop)
);

// File: usb_rx_tb.sv
// Drives USB packets at 4 clocks per bit and reads the FIFO over Wishbone.
// Expected entries come from the packet table; stuffing counts the last SYNC bit.
`timescale 1ns/1ps

module usb_rx_tb;

  typedef struct packed {
    int num_bytes;
    int ff_bytes;   // leading 8'hff bytes to force stuffing
    int se0_byte;   // byte that gets an SE0 after 3 bits, -1 for none
    int enable;
    int skip_read;  // overflow test, no reads until the packet is done
  } test_t;

  localparam int num_tests = 6;
  localparam test_t tests [num_tests] = '{
    '{3, 0, -1, 1, 0},
    '{6, 3, -1, 1, 0},
    '{4, 0, 2, 1, 0},
    '{5, 1, -1, 1, 0},
    '{3, 0, -1, 0, 0},
    '{20, 2, -1, 1, 1}
  };

  logic                         clk;
  logic                         reset;
  logic                         usb_p;
  logic                         usb_n;
  logic                         cyc;
  logic                         stb;
  logic                         we;
  logic [usb_rx_pkg::adr_w-1:0] adr;
  logic [31:0]                  dat_w;
  logic [31:0]                  dat_r;
  logic                         ack;

  logic [31:0] seed = 32'hfecd;
  logic [1:0]  level;       // current line state for NRZI
  int          ones;        // consecutive ones sent
  logic [7:0]  pkt [32];
  int          cycles = 0;
  int          limit = 0;

  usb_rx_top DUT (
    .clk   (clk),
    .reset (reset),
    .usb_p (usb_p),
    .usb_n (usb_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  usb_rx_checker u_check (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .ack   (ack),
    .dat_r (dat_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [7:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[23:16];
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0: return "plain packet";
      1: return "ff runs";
      2: return "se0 mid-byte";
      3: return "packet after error";
      4: return "disabled";
      default: return "overflow";
    endcase
  endfunction

  // bits on the line times 4 plus register traffic
  function automatic int run_limit();
    int total;
    total = 1000;
    for (int t = 0; t < num_tests; t++)
      total += (40 + tests[t].num_bytes * 10) * 4 + (tests[t].num_bytes + 10) * 4;
    return total;
  endfunction

  task automatic drive_line(input logic [1:0] state, input int nbits);
    for (int i = 0; i < nbits; i++)
    begin
      usb_p = state[1];
      usb_n = state[0];
      repeat (usb_rx_pkg::samples_per_bit) @(negedge clk);
    end
  endtask

  task automatic send_nrzi(input logic b);
    if (!b)
      level = (level == usb_rx_pkg::line_j) ? usb_rx_pkg::line_k : usb_rx_pkg::line_j;
    drive_line(level, 1);
  endtask

  task automatic send_data_bit(input logic b);
    if (ones == usb_rx_pkg::stuff_limit)
    begin
      send_nrzi(1'b0);  // stuffed zero
      ones = 0;
    end
    send_nrzi(b);
    ones = b ? ones + 1 : 0;
  endtask

  task automatic send_packet(input int nbytes, input int se0_byte);
    level = usb_rx_pkg::line_j;
    drive_line(usb_rx_pkg::line_j, 4);
    for (int i = 0; i < 8; i++)  // SYNC is KJKJKJKK
      drive_line((i % 2 == 0 || i == 7) ? usb_rx_pkg::line_k : usb_rx_pkg::line_j, 1);
    level = usb_rx_pkg::line_k;
    ones = 1;
    for (int i = 0; i < nbytes; i++)
    begin
      for (int j = 0; j < 8; j++)
      begin
        if (i == se0_byte && j == 3)
        begin
          drive_line(usb_rx_pkg::line_z, 2);  // broken packet
          drive_line(usb_rx_pkg::line_j, 8);
          return;
        end
        send_data_bit(pkt[i][j]);
      end
    end
    if (ones == usb_rx_pkg::stuff_limit)
    begin
      send_nrzi(1'b0);
      ones = 0;
    end
    drive_line(usb_rx_pkg::line_z, 2);  // EOP
    level = usb_rx_pkg::line_j;
    drive_line(usb_rx_pkg::line_j, 5);
  endtask

  // classic cycle held until ack is sampled, then one idle cycle
  task automatic wb_access(input logic write, input logic [usb_rx_pkg::adr_w-1:0] a,
                           input logic [31:0] d);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    dat_w = d;
    @(negedge clk);
    while (!ack)
      @(negedge clk);
    @(negedge clk);  // strobe still high at the edge that samples ack
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
  endtask

  task automatic check_read(input string reg_name, input logic [usb_rx_pkg::adr_w-1:0] a,
                            input logic [31:0] value);
    u_check.expect_read(reg_name, value);
    wb_access(1'b0, a, 32'd0);
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit)
    begin
      $display("timeout after %0d cycles, run stopped", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  initial
  begin
    test_t cfg;
    int    exp_err;
    int    last;
    exp_err = 0;
    limit   = run_limit();
    reset   = 1'b1;
    usb_p   = 1'b1;  // idle J
    usb_n   = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = '0;
    dat_w   = '0;
    level   = usb_rx_pkg::line_j;
    ones    = 0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    for (int t = 0; t < num_tests; t++)
    begin
      cfg = tests[t];
      wb_access(1'b1, usb_rx_pkg::reg_ctrl, 32'(cfg.enable));
      for (int i = 0; i < cfg.num_bytes; i++)
        pkt[i] = (i < cfg.ff_bytes) ? 8'hff : next_rand();
      send_packet(cfg.num_bytes, cfg.se0_byte);
      if (cfg.se0_byte >= 0)
        exp_err++;

      if (cfg.skip_read != 0)
      begin
        check_read("status", usb_rx_pkg::reg_status, 32'h6);  // overflow and full
        for (int i = 0; i < usb_rx_pkg::fifo_depth; i++)
          check_read("data", usb_rx_pkg::reg_data, {24'd0, pkt[i]});
        check_read("data", usb_rx_pkg::reg_data, 32'h200);
        wb_access(1'b1, usb_rx_pkg::reg_ctrl, 32'h3);
        check_read("status", usb_rx_pkg::reg_status, 32'h1);
      end
      else
      begin
        if (cfg.enable != 0)
        begin
          last = (cfg.se0_byte >= 0) ? cfg.se0_byte : cfg.num_bytes;
          for (int i = 0; i < last; i++)
            check_read("data", usb_rx_pkg::reg_data, {24'd0, pkt[i]});
          if (cfg.se0_byte < 0)
            check_read("data", usb_rx_pkg::reg_data, 32'h100);  // eop marker
        end
        check_read("data", usb_rx_pkg::reg_data, 32'h200);
      end
      check_read("errcnt", usb_rx_pkg::reg_errcnt, 32'(exp_err));
      u_check.end_test(t, test_name(t));
    end

    u_check.report_counts();
    if (u_check.errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: usb_rx_sub.f
usb_rx_pkg.sv
usb_rx.sv
usb_rx_fifo.sv
usb_rx_regs.sv
usb_rx_top.sv
usb_rx_checker.sv
usb_rx_asserts.sv
usb_rx_tb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_rx_tb -f usb_rx_sub.f -o usb_rx_sim || exit 1
out="$(./obj_dir/usb_rx_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
